//--- hdl/fp48Pkg.sv
// ======================================
// 48-bit format: 1 sign, 11 exponent, 36 mantissa bits
// qnan is taken from the top mantissa bit alone
// ======================================

package fp48Pkg;

	// ======================================
	// format
	// ======================================
	localparam int MSB  = 47;	// top bit of the word
	localparam int EMSB = 10;	// top exponent bit
	localparam int FMSB = 35;	// top mantissa bit
	localparam int CLS_W = 10;	// width of the classify mask

	// sign 0, exponent all ones, only the quiet bit set
	localparam logic [MSB:0] canonNan = {1'b0, {(EMSB+1){1'b1}}, 1'b1, {FMSB{1'b0}}};

	typedef enum logic [2:0] {
		OP_MIN,
		OP_MAX,
		OP_CMP,
		OP_CLASS,
		OP_ABS,
		OP_NEG
	} fpOp_e;

	// ======================================
	// classify mask bit positions
	// ======================================
	localparam int CLS_NINF  = 0;
	localparam int CLS_NNORM = 1;
	localparam int CLS_NDEN  = 2;
	localparam int CLS_NZERO = 3;
	localparam int CLS_PZERO = 4;
	localparam int CLS_PDEN  = 5;
	localparam int CLS_PNORM = 6;
	localparam int CLS_PINF  = 7;
	localparam int CLS_SNAN  = 8;
	localparam int CLS_QNAN  = 9;

	// compare mask bits
	localparam int CMP_LT = 0;
	localparam int CMP_EQ = 1;
	localparam int CMP_GT = 2;
	localparam int CMP_UN = 3;	// either side NaN

	// decoded view of one operand
	typedef struct packed {
		logic [MSB:0]    raw;
		logic            sgn;
		logic [EMSB:0]   exp;
		logic [FMSB:0]   man;
		logic [FMSB+1:0] fract;	// mantissa with hidden bit
		logic            xz;	// exponent zero
		logic            mz;	// mantissa zero
		logic            vz;	// value zero
		logic            inf;	// infinity
		logic            xinf;	// exponent all ones
		logic            qnan;
		logic            snan;
		logic            nan;
	} fpFields_t;

	typedef struct packed {
		fpFields_t a;
		fpFields_t b;
		fpOp_e     op;
	} decStage_t;	// decode -> execute

	typedef struct packed {
		logic [MSB:0] value;	// mask sits in the low bits
		logic         isMask;
		logic         invalid;
	} execStage_t;	// execute -> result

endpackage

//--- hdl/fpDecomp48Reg.sv
// ======================================
// decode stage, one ce-qualified cycle of latency
// all flags are produced here and only read downstream
// ======================================
`timescale 1ns/100ps

module fpDecomp48Reg #(
	parameter int tagWidth = 4	// user tag width, 1 or more
) (
	input  logic                  clk,
	input  logic                  arstN,
	input  logic                  ce,	// stage enable
	input  logic                  inStb,	// one operation this cycle
	input  fp48Pkg::fpOp_e        op,
	input  logic [fp48Pkg::MSB:0] a,
	input  logic [fp48Pkg::MSB:0] b,
	input  logic [tagWidth-1:0]   inTag,
	output logic                  decStb,
	output fp48Pkg::decStage_t    dec,
	output logic [tagWidth-1:0]   decTag
);
	import fp48Pkg::*;

	// split a word into fields and class flags
	function automatic fpFields_t decomp(input logic [MSB:0] w);
		fpFields_t f;
		f.raw   = w;
		f.sgn   = w[MSB];
		f.exp   = w[MSB-1:FMSB+1];
		f.man   = w[FMSB:0];
		f.xz    = ~|f.exp;	// denormal or zero
		f.mz    = ~|f.man;
		f.vz    = f.xz & f.mz;
		f.xinf  = &f.exp;
		f.inf   = f.xinf & f.mz;
		f.nan   = f.xinf & ~f.mz;
		f.qnan  = f.xinf & f.man[FMSB];	// quiet bit set
		f.snan  = f.xinf & ~f.man[FMSB] & ~f.mz;
		f.fract = {~f.xz, f.man};	// hidden bit recovered
		return f;
	endfunction

	decStage_t decNext;

	always_comb begin
		decNext.a  = decomp(a);
		decNext.b  = decomp(b);
		decNext.op = op;
	end

	// data is cleared as well so the outputs start known
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			decStb <= 1'b0;
			dec    <= '0;
			decTag <= '0;
		end else if (ce) begin
			decStb <= inStb;
			dec    <= decNext;
			decTag <= inTag;	// tag rides with the operands
		end
	end

endmodule

//--- hdl/fpCmpExec.sv
// ======================================
// execute stage with ordering, NaN rules and opcode select
// -0 orders below +0 for MIN/MAX, equal for CMP
// ======================================
`timescale 1ns/100ps

module fpCmpExec #(
	parameter int tagWidth = 4
) (
	input  logic                 clk,
	input  logic                 arstN,
	input  logic                 ce,
	input  logic                 decStb,
	input  fp48Pkg::decStage_t   dec,
	input  logic [tagWidth-1:0]  decTag,
	output logic                 exStb,
	output fp48Pkg::execStage_t  ex,
	output logic [tagWidth-1:0]  exTag
);
	import fp48Pkg::*;

	logic             magLt, magEq;	// magnitude order only
	logic             bothZero;
	logic             lt, eq, gt;	// signed order, NaNs ignored
	logic             aBelow;	// a first in the total order
	logic             unord;
	logic [MSB:0]     minVal, maxVal;
	logic [3:0]       cmpMask;
	logic [CLS_W-1:0] clsMask;
	logic             aNorm;
	execStage_t       exNext;

	// ======================================
	// ordering
	// ======================================
	always_comb begin
		// exponent then fraction gives the magnitude order
		magLt    = {dec.a.exp, dec.a.fract} < {dec.b.exp, dec.b.fract};
		magEq    = {dec.a.exp, dec.a.fract} == {dec.b.exp, dec.b.fract};
		bothZero = dec.a.vz & dec.b.vz;
		eq       = bothZero | ((dec.a.sgn == dec.b.sgn) & magEq);
		if (bothZero)
			lt = 1'b0;
		else if (dec.a.sgn != dec.b.sgn)
			lt = dec.a.sgn;	// negative side is lower
		else if (dec.a.sgn)
			lt = ~magLt & ~magEq;	// both negative, bigger mag is lower
		else
			lt = magLt;
		gt     = ~lt & ~eq;
		aBelow = lt | (bothZero & dec.a.sgn & ~dec.b.sgn);	// -0 < +0
		unord  = dec.a.nan | dec.b.nan;

		// a single NaN yields the other operand
		if (dec.a.nan & dec.b.nan) begin
			minVal = canonNan;
			maxVal = canonNan;
		end else if (dec.a.nan) begin
			minVal = dec.b.raw;
			maxVal = dec.b.raw;
		end else if (dec.b.nan) begin
			minVal = dec.a.raw;
			maxVal = dec.a.raw;
		end else begin
			minVal = aBelow ? dec.a.raw : dec.b.raw;
			maxVal = aBelow ? dec.b.raw : dec.a.raw;
		end

		cmpMask = '0;
		if (unord)
			cmpMask[CMP_UN] = 1'b1;	// unordered only
		else begin
			cmpMask[CMP_LT] = lt;
			cmpMask[CMP_EQ] = eq;
			cmpMask[CMP_GT] = gt;
		end
	end

	// ======================================
	// classify + select
	// ======================================
	always_comb begin
		aNorm   = ~dec.a.xz & ~dec.a.xinf;
		clsMask = '0;
		clsMask[CLS_NINF]  = dec.a.inf & dec.a.sgn;
		clsMask[CLS_NNORM] = aNorm & dec.a.sgn;
		clsMask[CLS_NDEN]  = dec.a.xz & ~dec.a.mz & dec.a.sgn;
		clsMask[CLS_NZERO] = dec.a.vz & dec.a.sgn;
		clsMask[CLS_PZERO] = dec.a.vz & ~dec.a.sgn;
		clsMask[CLS_PDEN]  = dec.a.xz & ~dec.a.mz & ~dec.a.sgn;
		clsMask[CLS_PNORM] = aNorm & ~dec.a.sgn;
		clsMask[CLS_PINF]  = dec.a.inf & ~dec.a.sgn;
		clsMask[CLS_SNAN]  = dec.a.snan;
		clsMask[CLS_QNAN]  = dec.a.qnan;

		exNext = '0;
		case (dec.op)
			OP_MIN:   begin
				exNext.value   = minVal;
				exNext.invalid = dec.a.snan | dec.b.snan;
			end
			OP_MAX:   begin
				exNext.value   = maxVal;
				exNext.invalid = dec.a.snan | dec.b.snan;
			end
			OP_CMP:   begin
				exNext.value[3:0] = cmpMask;
				exNext.isMask     = 1'b1;
				exNext.invalid    = dec.a.snan | dec.b.snan;
			end
			OP_CLASS: begin
				exNext.value[CLS_W-1:0] = clsMask;	// never invalid
				exNext.isMask           = 1'b1;
			end
			OP_ABS:   begin
				exNext.value   = {1'b0, dec.a.exp, dec.a.man};
				exNext.invalid = dec.a.snan;
			end
			OP_NEG:   begin
				exNext.value   = {~dec.a.sgn, dec.a.exp, dec.a.man};
				exNext.invalid = dec.a.snan;
			end
			default:  exNext.value = dec.a.raw;	// spare codes pass a
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			exStb <= 1'b0;
			ex    <= '0;
			exTag <= '0;
		end else if (ce) begin
			exStb <= decStb;
			ex    <= exNext;
			exTag <= decTag;
		end
	end

endmodule

//--- hdl/fpResultFmt.sv
// ======================================
// result stage, invalid is a pulse qualified by outStb
// ======================================
`timescale 1ns/100ps

module fpResultFmt #(
	parameter int tagWidth = 4
) (
	input  logic                  clk,
	input  logic                  arstN,
	input  logic                  ce,
	input  logic                  exStb,
	input  fp48Pkg::execStage_t   ex,
	input  logic [tagWidth-1:0]   exTag,
	output logic                  outStb,	// one result this cycle
	output logic [fp48Pkg::MSB:0] res,
	output logic                  invalid,
	output logic [tagWidth-1:0]   outTag
);
	import fp48Pkg::*;

	logic [MSB:0] resNext;

	// masks keep only their low CLS_W bits, values pass whole
	always_comb begin
		if (ex.isMask)
			resNext = {{(MSB+1-CLS_W){1'b0}}, ex.value[CLS_W-1:0]};
		else
			resNext = ex.value;
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			outStb  <= 1'b0;
			res     <= '0;
			invalid <= 1'b0;
			outTag  <= '0;
		end else if (ce) begin
			outStb  <= exStb;
			res     <= resNext;
			invalid <= ex.invalid & exStb;	// low between results
			outTag  <= exTag;
		end
	end

endmodule

//--- hdl/fpCmpUnit.sv
// ======================================
// 3-stage compare/sign unit, result 3 ce edges after inStb
// ce low holds every stage, strobes included
// ======================================
`timescale 1ns/100ps

module fpCmpUnit #(
	parameter int tagWidth = 4
) (
	input  logic                  clk,
	input  logic                  arstN,
	input  logic                  ce,
	input  logic                  inStb,
	input  fp48Pkg::fpOp_e        op,
	input  logic [fp48Pkg::MSB:0] a,
	input  logic [fp48Pkg::MSB:0] b,
	input  logic [tagWidth-1:0]   inTag,
	output logic                  outStb,
	output logic [fp48Pkg::MSB:0] res,
	output logic                  invalid,
	output logic [tagWidth-1:0]   outTag
);
	import fp48Pkg::*;

	// ======================================
	// stage links
	// ======================================
	logic                decStb, exStb;
	decStage_t           dec;	// decode -> execute
	execStage_t          ex;	// execute -> result
	logic [tagWidth-1:0] decTag, exTag;

	fpDecomp48Reg #(.tagWidth(tagWidth)) fpDecomp48Reg_i (
		.clk(clk), .arstN(arstN), .ce(ce),
		.inStb(inStb), .op(op), .a(a), .b(b), .inTag(inTag),
		.decStb(decStb), .dec(dec), .decTag(decTag)
	);

	fpCmpExec #(.tagWidth(tagWidth)) fpCmpExec_i (
		.clk(clk), .arstN(arstN), .ce(ce),
		.decStb(decStb), .dec(dec), .decTag(decTag),
		.exStb(exStb), .ex(ex), .exTag(exTag)
	);

	fpResultFmt #(.tagWidth(tagWidth)) fpResultFmt_i (
		.clk(clk), .arstN(arstN), .ce(ce),
		.exStb(exStb), .ex(ex), .exTag(exTag),
		.outStb(outStb), .res(res), .invalid(invalid), .outTag(outTag)
	);

endmodule

//--- verif/fpCmpUnit_chk.sv
// ========================================
// bound into fpCmpUnit, latency counted in ce-high edges only
// ========================================
`timescale 1ns/100ps

module fpCmpUnit_chk #(
	parameter int tagWidth = 4
) (
	input logic                  clk,
	input logic                  arstN,
	input logic                  ce,
	input logic                  inStb,
	input logic                  outStb,
	input logic                  invalid,
	input logic [fp48Pkg::MSB:0] res,
	input logic [tagWidth-1:0]   outTag
);

	// strobe stays low while reset is held
	resetQuiet: assert property (@(posedge clk) !arstN |-> !outStb)
		else $error("outStb high during reset");

	// sampled at edge k, result visible after two more ce edges plus this one
	latency: assert property (@(posedge clk) disable iff (!arstN)
		ce && inStb |=> ce[->2] ##1 outStb)
		else $error("no outStb three enabled edges after inStb");

	invalidQualified: assert property (@(posedge clk) disable iff (!arstN) invalid |-> outStb)
		else $error("invalid high without outStb");

	holdOnCe: assert property (@(posedge clk) disable iff (!arstN)
		!ce |=> $stable({outStb, invalid, res, outTag}))
		else $error("outputs moved while ce was low");

endmodule

bind fpCmpUnit fpCmpUnit_chk #(.tagWidth(tagWidth)) fpCmpUnit_chk_i (.*);

//--- verif/fpCmpUnit_tb.sv
// ========================================
// directed table first, then 40 random ABS/NEG/CLASS rows with ce dropping
// tags are row indices, so the DUT is built with an 8-bit tag
// ========================================
`timescale 1ns/100ps

module fpCmpUnit_tb;
	import fp48Pkg::*;

	localparam int tagWidth = 8;
	localparam int nRand    = 40;
	localparam logic [MSB:0] P1   = 48'h3FF000000000;	// +1.0
	localparam logic [MSB:0] P2   = 48'h400000000000;	// +2.0
	localparam logic [MSB:0] N1   = 48'hBFF000000000;
	localparam logic [MSB:0] N2   = 48'hC00000000000;
	localparam logic [MSB:0] PZ   = 48'h000000000000;
	localparam logic [MSB:0] NZ   = 48'h800000000000;
	localparam logic [MSB:0] PINF = 48'h7FF000000000;
	localparam logic [MSB:0] NINF = 48'hFFF000000000;
	localparam logic [MSB:0] QNAN = 48'h7FF800000000;	// same as canonNan
	localparam logic [MSB:0] QNANP = 48'hFFF800000123;	// negative quiet NaN with payload
	localparam logic [MSB:0] SNAN = 48'h7FF000000001;
	localparam logic [MSB:0] PDEN = 48'h000000000001;
	localparam logic [MSB:0] NDEN = 48'h800000000001;

	typedef struct packed {
		fpOp_e               op;
		logic [MSB:0]        a;
		logic [MSB:0]        b;
		logic [MSB:0]        res;	// expected result word
		logic                inv;	// expected invalid
		logic [tagWidth-1:0] tag;
	} row_t;

	row_t tableQ[$];	// stimulus table
	row_t expQ[$];	// scoreboard, in issue order
	row_t want;
	logic clk, arstN, ce, inStb, outStb, invalid;
	fpOp_e op;
	logic [MSB:0] a, b, res;
	logic [tagWidth-1:0] inTag, outTag;
	logic [31:0] lfsr = 32'ha1d4e078;
	logic ceSeen = 1'b0;	// ce at the last rising edge
	int errors = 0;
	int passes = 0;

	fpCmpUnit #(.tagWidth(tagWidth)) fpCmpUnit_i (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ========================================
	// helpers
	// ========================================
	function automatic logic lfsrStep();
		lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);	// galois taps 32,22,2,1
		return lfsr[0];
	endfunction

	function automatic logic [MSB:0] takeBits(input int n);
		logic [MSB:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[MSB-1:0], lfsrStep()};
		return v;
	endfunction

	// bias toward zero / all-ones exponents so every class shows up
	function automatic logic [MSB:0] makeOperand();
		logic [MSB:0] w;
		logic [1:0]   kind;
		w    = takeBits(48);
		kind = 2'(takeBits(2));
		if (kind == 2'd0) w[MSB-1:FMSB+1] = '0;
		if (kind == 2'd3) w[MSB-1:FMSB+1] = '1;
		if (takeBits(2) == 0) w[FMSB:0] = '0;	// zeros and infinities
		return w;
	endfunction

	// expected outcome of ABS, NEG or CLASS on x
	function automatic row_t expectFor(input fpOp_e o, input logic [MSB:0] x, input logic [MSB:0] y);
		row_t r;
		logic [EMSB:0] e;
		logic [FMSB:0] m;
		logic isNan, isSnan;
		int cls;
		e      = x[MSB-1:FMSB+1];
		m      = x[FMSB:0];
		isNan  = (&e) && (m != 0);
		isSnan = isNan && !m[FMSB];
		if (isNan) cls = isSnan ? 8 : 9;
		else if (&e) cls = x[MSB] ? 0 : 7;
		else if (e == 0 && m == 0) cls = x[MSB] ? 3 : 4;
		else if (e == 0) cls = x[MSB] ? 2 : 5;
		else cls = x[MSB] ? 1 : 6;
		r = '{op: o, a: x, b: y, res: '0, inv: isSnan, tag: '0};
		if (o == OP_ABS) r.res = {1'b0, x[MSB-1:0]};
		else if (o == OP_NEG) r.res = {~x[MSB], x[MSB-1:0]};
		else begin
			r.res = 48'h1 << cls;	// one-hot class, never invalid
			r.inv = 1'b0;
		end
		return r;
	endfunction

	task automatic addRow(input fpOp_e o, input logic [MSB:0] x, input logic [MSB:0] y,
			input logic [MSB:0] r, input logic inv);
		tableQ.push_back('{op: o, a: x, b: y, res: r, inv: inv, tag: '0});
	endtask

	// hold the row until an edge with ce high picks it up
	task automatic sendRow(input row_t r, input int idx, input logic randomCe);
		row_t e;
		e     = r;
		e.tag = idx[tagWidth-1:0];
		@(negedge clk);
		op    = r.op;
		a     = r.a;
		b     = r.b;
		inTag = e.tag;
		inStb = 1'b1;
		ce    = randomCe ? (takeBits(2) != 0) : 1'b1;
		while (!ce) begin
			@(negedge clk);
			ce = (takeBits(2) != 0);
		end
		expQ.push_back(e);
	endtask

	// ========================================
	// scoreboard reads outputs mid-cycle
	// ========================================
	always @(posedge clk) ceSeen <= ce && arstN;

	always @(negedge clk) begin
		if (ceSeen && outStb) begin	// one new result per enabled edge
			if (expQ.size() == 0) begin
				$display("unexpected result with tag %0d at %0t", outTag, $time);
				errors++;
			end else begin
				want = expQ.pop_front();
				if (outTag !== want.tag || res !== want.res || invalid !== want.inv) begin
					$display("MISMATCH at %0t: tag %0d %s got res %h inv %b tag %0d, want res %h inv %b",
						$time, want.tag, want.op.name(), res, invalid, outTag, want.res, want.inv);
					errors++;
				end else begin
					$display("test %0d %s ok", want.tag, want.op.name());
					passes++;
				end
			end
		end
	end

	initial begin
		@(posedge arstN);
		repeat ((tableQ.size() + nRand) * 20) @(posedge clk);
		$display("timeout: %0d results never came back", expQ.size());
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		fpOp_e        rOp;
		logic [MSB:0] rA, rB;
		logic [1:0]   sel;
		arstN = 1'b0;
		ce    = 1'b0;
		inStb = 1'b0;
		op    = OP_MIN;
		a     = '0;
		b     = '0;
		inTag = '0;
		addRow(OP_MIN, P1, P2, P1, 1'b0);
		addRow(OP_MIN, N1, P1, N1, 1'b0);
		addRow(OP_MAX, N2, N1, N1, 1'b0);
		addRow(OP_MIN, PZ, NZ, NZ, 1'b0);	// -0 below +0
		addRow(OP_MAX, NZ, PZ, PZ, 1'b0);
		addRow(OP_MIN, QNAN, P2, P2, 1'b0);
		addRow(OP_MAX, N2, QNAN, N2, 1'b0);	// NaN on the b side
		addRow(OP_MIN, SNAN, QNANP, QNAN, 1'b1);	// two NaNs give canonNan
		addRow(OP_MAX, SNAN, P1, P1, 1'b1);
		addRow(OP_CMP, P1, P2, 48'h1, 1'b0);
		addRow(OP_CMP, P2, P2, 48'h2, 1'b0);
		addRow(OP_CMP, N1, N2, 48'h4, 1'b0);
		addRow(OP_CMP, PZ, NZ, 48'h2, 1'b0);
		addRow(OP_CMP, QNAN, P1, 48'h8, 1'b0);
		addRow(OP_CMP, P1, SNAN, 48'h8, 1'b1);
		addRow(OP_CLASS, NINF, PZ, 48'h001, 1'b0);
		addRow(OP_CLASS, N1, PZ, 48'h002, 1'b0);
		addRow(OP_CLASS, NDEN, PZ, 48'h004, 1'b0);
		addRow(OP_CLASS, NZ, PZ, 48'h008, 1'b0);
		addRow(OP_CLASS, PZ, PZ, 48'h010, 1'b0);
		addRow(OP_CLASS, PDEN, PZ, 48'h020, 1'b0);
		addRow(OP_CLASS, P1, PZ, 48'h040, 1'b0);
		addRow(OP_CLASS, PINF, PZ, 48'h080, 1'b0);
		addRow(OP_CLASS, SNAN, PZ, 48'h100, 1'b0);
		addRow(OP_CLASS, QNAN, PZ, 48'h200, 1'b0);
		addRow(OP_ABS, N2, PZ, P2, 1'b0);
		addRow(OP_ABS, P1, SNAN, P1, 1'b0);	// b is unused for invalid
		addRow(OP_NEG, PINF, PZ, NINF, 1'b0);
		addRow(OP_NEG, QNAN, PZ, 48'hFFF800000000, 1'b0);
		addRow(OP_NEG, SNAN, PZ, 48'hFFF000000001, 1'b1);
		repeat (8) @(negedge clk);
		arstN = 1'b1;
		foreach (tableQ[i])
			sendRow(tableQ[i], i, 1'b0);
		for (int i = 0; i < nRand; i++) begin
			sel = 2'(takeBits(2));
			rOp = (sel == 2'd0) ? OP_ABS : (sel == 2'd1) ? OP_NEG : OP_CLASS;
			rA  = makeOperand();
			rB  = makeOperand();
			sendRow(expectFor(rOp, rA, rB), tableQ.size() + i, 1'b1);
		end
		@(negedge clk);
		inStb = 1'b0;
		ce    = 1'b1;
		while (expQ.size() != 0)
			@(negedge clk);
		repeat (4) @(negedge clk);	// room for a stray extra result
		$display("%0d passed, %0d failed", passes, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

//--- sources.f
hdl/fp48Pkg.sv
hdl/fpDecomp48Reg.sv
hdl/fpCmpExec.sv
hdl/fpResultFmt.sv
hdl/fpCmpUnit.sv
verif/fpCmpUnit_chk.sv
verif/fpCmpUnit_tb.sv

//--- Bender.yml
package:
  name: fp_cmp_unit

sources:
  # design, package first
  - files:
      - hdl/fp48Pkg.sv
      - hdl/fpDecomp48Reg.sv
      - hdl/fpCmpExec.sv
      - hdl/fpResultFmt.sv
      - hdl/fpCmpUnit.sv

  # bound checker and testbench
  - target: simulation
    files:
      - verif/fpCmpUnit_chk.sv
      - verif/fpCmpUnit_tb.sv
